// File: source/rob_defs.svh
`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

// Datapath width in bits
`define XLEN 32

// Reorder buffer entries and tag bits (TAG_W is log2 of ROB_DEPTH)
`define ROB_DEPTH 16
`define TAG_W 4

`endif

// File: source/rob_pkg.sv
`default_nettype none

`include "rob_defs.svh"

package rob_pkg;

    typedef logic [`XLEN-1:0]  data_t;    // Operands and results
    typedef logic [`TAG_W-1:0] tag_t;     // Buffer index
    typedef logic [4:0]        reg_t;     // Architectural destination

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_XOR,
        OP_MUL,                           // Low word of product
        OP_DIVU,
        OP_REMU
    } op_t;

    typedef enum logic [1:0] {
        ENT_FREE,
        ENT_BUSY,                         // Issued and waiting for its result
        ENT_DONE,                         // Result written and ready to retire
        ENT_KILLED                        // Discarded by flush
    } ent_state_t;

    typedef enum logic {
        CTRL_RUN,
        CTRL_DRAIN                        // Waiting for stale unit results
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: source/issue_if.sv
`timescale 1ns/1ps
`default_nettype none

interface issue_if import rob_pkg::*;;

    logic  valid;                         // Transfer this cycle
    logic  ready;                         // Unit can take an operation
    tag_t  tag;                           // Buffer slot of the operation
    op_t   op;
    data_t src_a;
    data_t src_b;

    // Operands are fed from dispatch at the core level
    modport ctrl (
        output valid,
        output tag,
        output op,
        input  ready
    );

    modport unit (
        input  valid,
        input  tag,
        input  op,
        input  src_a,
        input  src_b,
        output ready
    );

endinterface

`default_nettype wire

// File: source/rob_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_defs.svh"

module rob_ctrl import rob_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire         disp_valid,
    input  wire op_t    disp_op,
    output logic        disp_ready,
    input  wire         flush,
    issue_if.ctrl       alu_iss,
    issue_if.ctrl       mul_iss,
    issue_if.ctrl       div_iss,
    input  wire         alu_wb_valid,
    input  wire tag_t   alu_wb_tag,
    input  wire         mul_wb_valid,
    input  wire tag_t   mul_wb_tag,
    input  wire         div_wb_valid,
    input  wire tag_t   div_wb_tag,
    output tag_t        disp_tag,
    output logic        disp_write,
    output tag_t        head_tag,
    output logic        commit_valid
);

    localparam int CNT_W = `TAG_W + 1;

    ctrl_state_t      state_q;
    ent_state_t       ent_q [`ROB_DEPTH];
    tag_t             head_q;                 // Oldest entry
    tag_t             tail_q;                 // Next free slot
    logic [CNT_W-1:0] count_q;                // Occupied entries
    logic [2:0]       fl_q [3];               // In flight per unit
    logic             sel_alu;
    logic             sel_mul;
    logic             sel_div;
    logic             unit_ready;
    logic             full;
    logic             do_commit;
    logic             drained;
    logic [2:0]       iss_v;                  // Index 0 alu, 1 mul, 2 div
    logic [2:0]       wb_v;
    tag_t             wb_tag [3];

    // Unit select from op code
    assign sel_mul    = disp_op == OP_MUL;
    assign sel_div    = disp_op == OP_DIVU || disp_op == OP_REMU;
    assign sel_alu    = !sel_mul && !sel_div;
    assign unit_ready = sel_alu ? alu_iss.ready : (sel_mul ? mul_iss.ready : div_iss.ready);

    assign full       = count_q == CNT_W'(`ROB_DEPTH);
    assign disp_ready = state_q == CTRL_RUN && !full && !flush && unit_ready;
    assign disp_write = disp_valid && disp_ready;
    assign disp_tag   = tail_q;
    assign head_tag   = head_q;

    // Issue rides on the dispatch handshake with the tail tag
    assign alu_iss.valid = disp_write && sel_alu;
    assign alu_iss.tag   = tail_q;
    assign alu_iss.op    = disp_op;
    assign mul_iss.valid = disp_write && sel_mul;
    assign mul_iss.tag   = tail_q;
    assign mul_iss.op    = disp_op;
    assign div_iss.valid = disp_write && sel_div;
    assign div_iss.tag   = tail_q;
    assign div_iss.op    = disp_op;

    assign iss_v     = {div_iss.valid, mul_iss.valid, alu_iss.valid};
    assign wb_v      = {div_wb_valid, mul_wb_valid, alu_wb_valid};
    assign wb_tag[0] = alu_wb_tag;
    assign wb_tag[1] = mul_wb_tag;
    assign wb_tag[2] = div_wb_tag;

    assign do_commit = !flush && ent_q[head_q] == ENT_DONE;   // Flush blocks retire
    assign drained   = fl_q[0] == '0 && fl_q[1] == '0 && fl_q[2] == '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q      <= CTRL_RUN;
            head_q       <= '0;
            tail_q       <= '0;
            count_q      <= '0;
            commit_valid <= 1'b0;
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                ent_q[i] <= ENT_FREE;
            end
            for (int u = 0; u < 3; u++) begin
                fl_q[u] <= '0;
            end
        end else begin
            commit_valid <= do_commit;          // Storage read aligns with this
            for (int u = 0; u < 3; u++) begin
                fl_q[u] <= fl_q[u] + 3'(iss_v[u]) - 3'(wb_v[u]);
                if (wb_v[u] && ent_q[wb_tag[u]] == ENT_BUSY) begin
                    ent_q[wb_tag[u]] <= ENT_DONE;   // Killed slots stay killed
                end
            end
            if (disp_write) begin
                ent_q[tail_q] <= ENT_BUSY;
                tail_q        <= tail_q + 1'b1;
            end
            if (do_commit) begin
                ent_q[head_q] <= ENT_FREE;
                head_q        <= head_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(disp_write) - CNT_W'(do_commit);
            if (flush) begin
                state_q <= CTRL_DRAIN;
                for (int i = 0; i < `ROB_DEPTH; i++) begin
                    if (ent_q[i] == ENT_BUSY || ent_q[i] == ENT_DONE) begin
                        ent_q[i] <= ENT_KILLED;     // Overrides a same edge writeback
                    end
                end
            end else if (state_q == CTRL_DRAIN && drained) begin
                // No stale result left so tags are safe to reuse
                state_q <= CTRL_RUN;
                head_q  <= tail_q;
                count_q <= '0;
                for (int i = 0; i < `ROB_DEPTH; i++) begin
                    ent_q[i] <= ENT_FREE;
                end
            end
        end
    end

    // Tail slot has been retired before it is reused
    a_tail_free: assert property (@(posedge clk) disable iff (rst)
        disp_write |-> ent_q[tail_q] == ENT_FREE);

    for (genvar u = 0; u < 3; u++) begin : g_wb_chk
        // Units only answer for live or killed slots
        a_wb_live: assert property (@(posedge clk) disable iff (rst)
            wb_v[u] |-> ent_q[wb_tag[u]] != ENT_FREE);
    end

endmodule

`default_nettype wire

// File: source/rob_storage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_defs.svh"

module rob_storage import rob_pkg::*; (
    input  wire         clk,
    input  wire         disp_write,
    input  wire tag_t   disp_tag,
    input  wire reg_t   disp_dest,
    input  wire         disp_reg_write,
    input  wire         alu_wb_valid,
    input  wire tag_t   alu_wb_tag,
    input  wire data_t  alu_wb_value,
    input  wire         mul_wb_valid,
    input  wire tag_t   mul_wb_tag,
    input  wire data_t  mul_wb_value,
    input  wire         div_wb_valid,
    input  wire tag_t   div_wb_tag,
    input  wire data_t  div_wb_value,
    input  wire tag_t   head_tag,
    output reg_t        commit_dest,
    output data_t       commit_value,
    output logic        commit_reg_write
);

    reg_t                  dest_q  [`ROB_DEPTH];  // Destination per entry
    logic [`ROB_DEPTH-1:0] wr_q;                  // Register write flag
    data_t                 value_q [`ROB_DEPTH];  // Result per entry

    always_ff @(posedge clk) begin
        if (disp_write) begin
            dest_q[disp_tag] <= disp_dest;
            wr_q[disp_tag]   <= disp_reg_write;
        end
        // Writeback ports by tag
        if (alu_wb_valid) begin
            value_q[alu_wb_tag] <= alu_wb_value;
        end
        if (mul_wb_valid) begin
            value_q[mul_wb_tag] <= mul_wb_value;
        end
        if (div_wb_valid) begin
            value_q[div_wb_tag] <= div_wb_value;
        end
        // Head read lands with commit_valid
        commit_dest      <= dest_q[head_tag];
        commit_value     <= value_q[head_tag];
        commit_reg_write <= wr_q[head_tag];
    end

    // Each tag is owned by exactly one unit at a time
    a_wb_unique: assert property (@(posedge clk)
        !(alu_wb_valid && mul_wb_valid && alu_wb_tag == mul_wb_tag) &&
        !(alu_wb_valid && div_wb_valid && alu_wb_tag == div_wb_tag) &&
        !(mul_wb_valid && div_wb_valid && mul_wb_tag == div_wb_tag));

endmodule

`default_nettype wire

// File: source/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit import rob_pkg::*; (
    input  wire     clk,
    input  wire     rst,
    issue_if.unit   iss,
    output logic    wb_valid,
    output tag_t    wb_tag,
    output data_t   wb_value
);

    data_t res;

    assign iss.ready = 1'b1;                  // Never stalls

    always_comb begin
        case (iss.op)
            OP_SUB:  res = iss.src_a - iss.src_b;
            OP_AND:  res = iss.src_a & iss.src_b;
            OP_XOR:  res = iss.src_a ^ iss.src_b;
            default: res = iss.src_a + iss.src_b;   // OP_ADD
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= iss.valid;            // One cycle after acceptance
        end
    end

    always_ff @(posedge clk) begin
        wb_tag   <= iss.tag;
        wb_value <= res;
    end

endmodule

`default_nettype wire

// File: source/mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_defs.svh"

module mul_unit import rob_pkg::*; (
    input  wire     clk,
    input  wire     rst,
    issue_if.unit   iss,
    output logic    wb_valid,
    output tag_t    wb_tag,
    output data_t   wb_value
);

    localparam int HALF = `XLEN / 2;

    data_t           a_q;                     // Stage 1 operands
    data_t           b_q;
    data_t           pp_lo_q;                 // Stage 2 a times low half of b
    logic [HALF-1:0] pp_hi_q;                 // Upper partial that survives the shift
    logic            v1_q;
    logic            v2_q;
    tag_t            t1_q;
    tag_t            t2_q;

    assign iss.ready = 1'b1;                  // Fully pipelined

    always_ff @(posedge clk) begin
        if (rst) begin
            v1_q     <= 1'b0;
            v2_q     <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            v1_q     <= iss.valid;
            v2_q     <= v1_q;
            wb_valid <= v2_q;                 // Three cycles after acceptance
        end
    end

    always_ff @(posedge clk) begin
        a_q      <= iss.src_a;
        b_q      <= iss.src_b;
        t1_q     <= iss.tag;
        pp_lo_q  <= a_q * data_t'(b_q[HALF-1:0]);
        pp_hi_q  <= a_q[HALF-1:0] * b_q[`XLEN-1:HALF];
        t2_q     <= t1_q;
        wb_value <= pp_lo_q + {pp_hi_q, {HALF{1'b0}}};   // Low word only
        wb_tag   <= t2_q;
    end

endmodule

`default_nettype wire

// File: source/div_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_defs.svh"

module div_unit import rob_pkg::*; (
    input  wire     clk,
    input  wire     rst,
    issue_if.unit   iss,
    output logic    wb_valid,
    output tag_t    wb_tag,
    output data_t   wb_value
);

    localparam int STEPS = `XLEN;             // One quotient bit per step
    localparam int CNT_W = $clog2(STEPS);

    logic             busy_q;
    logic [CNT_W-1:0] cnt_q;
    logic             rem_sel_q;              // Return remainder
    tag_t             tag_q;
    data_t            dvs_q;                  // Divisor
    data_t            quo_q;                  // Dividend shifting out and quotient in
    data_t            rem_q;                  // Partial remainder
    logic [`XLEN:0]   shifted;
    logic [`XLEN:0]   diff;
    logic             take;
    logic             last;
    data_t            quo_nx;
    data_t            rem_nx;

    assign iss.ready = !busy_q;

    // Restoring step
    assign shifted = {rem_q, quo_q[`XLEN-1]};
    assign diff    = shifted - {1'b0, dvs_q};
    assign take    = shifted >= {1'b0, dvs_q};    // Always true for a zero divisor
    assign rem_nx  = take ? diff[`XLEN-1:0] : shifted[`XLEN-1:0];
    assign quo_nx  = {quo_q[`XLEN-2:0], take};
    assign last    = busy_q && cnt_q == CNT_W'(STEPS - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q   <= 1'b0;
            cnt_q    <= '0;
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= last;                 // Result cycle after final step
            if (iss.valid) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end else if (busy_q) begin
                cnt_q <= cnt_q + 1'b1;
                if (last) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (iss.valid) begin
            dvs_q     <= iss.src_b;
            quo_q     <= iss.src_a;
            rem_q     <= '0;
            tag_q     <= iss.tag;
            rem_sel_q <= iss.op == OP_REMU;
        end else if (busy_q) begin
            quo_q <= quo_nx;
            rem_q <= rem_nx;
        end
        if (last) begin
            wb_tag   <= tag_q;
            wb_value <= rem_sel_q ? rem_nx : quo_nx;
        end
    end

    // Control block must honour ready across the whole divide
    a_no_issue_busy: assert property (@(posedge clk) disable iff (rst)
        busy_q |-> !iss.valid);

endmodule

`default_nettype wire

// File: source/ooo_core.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_core import rob_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire         disp_valid,
    input  wire op_t    disp_op,
    input  wire data_t  disp_src_a,
    input  wire data_t  disp_src_b,
    input  wire reg_t   disp_dest,
    input  wire         disp_reg_write,
    output logic        disp_ready,
    input  wire         flush,
    output logic        commit_valid,
    output reg_t        commit_dest,
    output data_t       commit_value,
    output logic        commit_reg_write
);

    issue_if alu_iss ();
    issue_if mul_iss ();
    issue_if div_iss ();

    logic  alu_wb_valid;
    tag_t  alu_wb_tag;
    data_t alu_wb_value;
    logic  mul_wb_valid;
    tag_t  mul_wb_tag;
    data_t mul_wb_value;
    logic  div_wb_valid;
    tag_t  div_wb_tag;
    data_t div_wb_value;
    tag_t  disp_tag;
    logic  disp_write;
    tag_t  head_tag;

    // Operands fan out to all units and issue valid picks the target
    assign alu_iss.src_a = disp_src_a;
    assign alu_iss.src_b = disp_src_b;
    assign mul_iss.src_a = disp_src_a;
    assign mul_iss.src_b = disp_src_b;
    assign div_iss.src_a = disp_src_a;
    assign div_iss.src_b = disp_src_b;

    rob_ctrl i_ctrl (
        .clk, .rst, .disp_valid, .disp_op, .disp_ready, .flush,
        .alu_iss (alu_iss.ctrl),
        .mul_iss (mul_iss.ctrl),
        .div_iss (div_iss.ctrl),
        .alu_wb_valid, .alu_wb_tag,
        .mul_wb_valid, .mul_wb_tag,
        .div_wb_valid, .div_wb_tag,
        .disp_tag, .disp_write, .head_tag, .commit_valid
    );

    rob_storage i_storage (
        .clk, .disp_write, .disp_tag, .disp_dest, .disp_reg_write,
        .alu_wb_valid, .alu_wb_tag, .alu_wb_value,
        .mul_wb_valid, .mul_wb_tag, .mul_wb_value,
        .div_wb_valid, .div_wb_tag, .div_wb_value,
        .head_tag, .commit_dest, .commit_value, .commit_reg_write
    );

    alu_unit i_alu (
        .clk, .rst,
        .iss      (alu_iss.unit),
        .wb_valid (alu_wb_valid),
        .wb_tag   (alu_wb_tag),
        .wb_value (alu_wb_value)
    );

    mul_unit i_mul (
        .clk, .rst,
        .iss      (mul_iss.unit),
        .wb_valid (mul_wb_valid),
        .wb_tag   (mul_wb_tag),
        .wb_value (mul_wb_value)
    );

    div_unit i_div (
        .clk, .rst,
        .iss      (div_iss.unit),
        .wb_valid (div_wb_valid),
        .wb_tag   (div_wb_tag),
        .wb_value (div_wb_value)
    );

endmodule

`default_nettype wire

// File: test/tb_ooo_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_core import rob_pkg::*;;

    localparam int unsigned SEED = 32'hb567_5cc1;
    localparam int TIMEOUT = 1000;                // Cycles allowed per wait

    typedef struct packed {
        reg_t  dest;
        data_t value;
        logic  wr;
    } exp_t;

    logic        clk;
    logic        rst;
    logic        disp_valid;
    op_t         disp_op;
    data_t       disp_src_a;
    data_t       disp_src_b;
    reg_t        disp_dest;
    logic        disp_reg_write;
    logic        disp_ready;
    logic        flush;
    logic        commit_valid;
    reg_t        commit_dest;
    data_t       commit_value;
    logic        commit_reg_write;

    exp_t        exp_q [$];                       // Accepted ops in program order
    int          value_errors = 0;
    int          other_errors = 0;
    int          timeouts = 0;
    int          commits = 0;
    int          stalls = 0;                      // Cycles with valid but not ready
    int unsigned seed_ret;

    // Directed divide operands with zero divisors
    data_t div_a [10] = '{32'd100, 32'd7, 32'd0, 32'd5, 32'd0, 32'hffff_ffff,
                          32'hffff_ffff, 32'h8000_0000, 32'hdead_beef, 32'd1};
    data_t div_b [10] = '{32'd7, 32'd100, 32'd5, 32'd0, 32'd0, 32'd1,
                          32'hffff_ffff, 32'd3, 32'd0, 32'h0001_0000};

    ooo_core i_dut (
        .clk              (clk),
        .rst              (rst),
        .disp_valid       (disp_valid),
        .disp_op          (disp_op),
        .disp_src_a       (disp_src_a),
        .disp_src_b       (disp_src_b),
        .disp_dest        (disp_dest),
        .disp_reg_write   (disp_reg_write),
        .disp_ready       (disp_ready),
        .flush            (flush),
        .commit_valid     (commit_valid),
        .commit_dest      (commit_dest),
        .commit_value     (commit_value),
        .commit_reg_write (commit_reg_write)
    );

    always #2 clk = ~clk;                         // 4 ns period

    // Reference result per op
    function automatic data_t model_result(input op_t op, input data_t a, input data_t b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_XOR:  return a ^ b;
            OP_MUL:  return a * b;                // Truncates to the low word
            OP_DIVU: return (b == '0) ? '1 : a / b;
            default: return (b == '0) ? a : a % b;   // OP_REMU
        endcase
    endfunction

    function automatic data_t pick_operand();
        case ($urandom % 4)
            0:       return data_t'($urandom % 16);     // Small values
            1:       return data_t'($urandom) >> ($urandom % 32);
            default: return data_t'($urandom);
        endcase
    endfunction

    function automatic op_t random_op();
        int unsigned r;
        r = $urandom % 8;
        if (r < 4) begin
            return op_t'(r);                      // ALU ops
        end
        if (r < 6) begin
            return OP_MUL;
        end
        return (r == 6) ? OP_DIVU : OP_REMU;
    endfunction

    // Commit checker and model update on pre-edge values
    always @(posedge clk) begin
        exp_t e;
        if (!rst) begin
            if (commit_valid) begin
                commits++;
                if (exp_q.size() == 0) begin
                    $display("commit at %0t while no operation is pending in the model", $time);
                    other_errors++;
                end else begin
                    e = exp_q.pop_front();
                    if (commit_dest !== e.dest || commit_value !== e.value ||
                        commit_reg_write !== e.wr) begin
                        $display("error at %0t: commit %0d %h %0b, expected %0d %h %0b",
                                 $time, commit_dest, commit_value, commit_reg_write,
                                 e.dest, e.value, e.wr);
                        value_errors++;
                    end
                end
            end
            if (flush) begin
                exp_q.delete();                   // Discarded ops never commit
            end
            if (disp_valid && disp_ready) begin
                exp_q.push_back('{dest: disp_dest, wr: disp_reg_write,
                                  value: model_result(disp_op, disp_src_a, disp_src_b)});
            end
            if (disp_valid && !disp_ready) begin
                stalls++;
            end
        end
    end

    task automatic dispatch(input op_t op, input data_t a, input data_t b);
        int waited;
        if (timeouts != 0) begin
            return;                               // Give up after a hang
        end
        @(negedge clk);
        disp_valid     = 1'b1;
        disp_op        = op;
        disp_src_a     = a;
        disp_src_b     = b;
        disp_dest      = reg_t'($urandom);
        disp_reg_write = ($urandom % 4) != 0;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!disp_ready && waited < TIMEOUT);
        if (!disp_ready) begin
            $display("timeout at %0t: disp_ready stayed low for %0d cycles", $time, TIMEOUT);
            timeouts++;
            @(negedge clk);
            disp_valid = 1'b0;
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            disp_valid = 1'b0;
        end
    endtask

    task automatic wait_empty();
        int waited;
        @(negedge clk);
        disp_valid = 1'b0;
        waited = 0;
        while (exp_q.size() != 0 && waited < TIMEOUT && timeouts == 0) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0 && timeouts == 0) begin
            $display("timeout at %0t: %0d operations never committed", $time, exp_q.size());
            timeouts++;
        end
    endtask

    task automatic flush_pipe();
        @(negedge clk);
        disp_valid = 1'b0;
        flush      = 1'b1;                        // Sampled at one edge only
        @(negedge clk);
        flush      = 1'b0;
        @(posedge clk);
        if (disp_ready) begin
            $display("error at %0t: disp_ready high right after a flush, expected low", $time);
            value_errors++;
        end
    endtask

    task automatic end_run();
        $display("errors: %0d value, %0d other, %0d timeout; %0d commits checked",
                 value_errors, other_errors, timeouts, commits);
        if (value_errors + other_errors + timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    initial begin
        int stalls_before;
        seed_ret       = $urandom(SEED);
        clk            = 1'b0;
        rst            = 1'b1;
        flush          = 1'b0;
        disp_valid     = 1'b0;
        disp_op        = OP_ADD;
        disp_src_a     = '0;
        disp_src_b     = '0;
        disp_dest      = '0;
        disp_reg_write = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        if (!disp_ready || commit_valid) begin
            $display("error at %0t: after reset disp_ready %0b commit_valid %0b, expected 1 0",
                     $time, disp_ready, commit_valid);
            value_errors++;
        end

        repeat (60) begin                         // ALU only with random gaps
            dispatch(op_t'($urandom % 4), pick_operand(), pick_operand());
            idle($urandom % 3);
        end
        wait_empty();

        repeat (150) begin                        // Mixed stream where divides get overtaken
            dispatch(random_op(), pick_operand(), pick_operand());
        end
        wait_empty();

        repeat (24) begin                         // Back to back multiplies
            dispatch(OP_MUL, data_t'($urandom), data_t'($urandom));
        end
        wait_empty();

        for (int i = 0; i < 10; i++) begin
            dispatch(OP_DIVU, div_a[i], div_b[i]);
            dispatch(OP_REMU, div_a[i], div_b[i]);
        end
        repeat (20) begin
            dispatch(($urandom % 2) ? OP_DIVU : OP_REMU, pick_operand(), pick_operand());
        end
        wait_empty();

        stalls_before = stalls;                   // Fill behind a long divide
        dispatch(OP_DIVU, data_t'($urandom), 32'd3);
        repeat (24) begin
            dispatch(op_t'($urandom % 4), pick_operand(), pick_operand());
        end
        wait_empty();
        if (stalls == stalls_before) begin
            $display("disp_ready never dropped while the buffer sat behind a divide");
            other_errors++;
        end

        repeat (4) begin                          // Flush mid stream then resume
            dispatch(OP_REMU, data_t'($urandom), pick_operand());
            repeat (10 + $urandom % 10) begin
                dispatch(random_op(), pick_operand(), pick_operand());
            end
            flush_pipe();
            repeat (20) begin
                dispatch(random_op(), pick_operand(), pick_operand());
            end
            wait_empty();
        end

        idle(8);                                  // Catch stray commits
        end_run();
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+source
source/rob_pkg.sv
source/issue_if.sv
source/rob_ctrl.sv
source/rob_storage.sv
source/alu_unit.sv
source/mul_unit.sv
source/div_unit.sv
source/ooo_core.sv
test/tb_ooo_core.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_ooo_core
FILELIST  = tb.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); test $$status -eq 0
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
